/* logic/vic20_pkg.sv */
// ================================================
// Shared definitions for the loader and tape path
//   Memory and machine address widths, data types
//   Address map for ROM regions, cartridge, tape
//   Download index codes and download kinds
//   Zero-page registers patched after a PRG load
// ================================================

package vic20_pkg;

    // ================================================
    // Widths and basic types
    // ================================================
    localparam int MEM_AW = 23;
    localparam int DL_AW  = 25;

    typedef logic [MEM_AW-1:0] mem_addr_t;
    typedef logic [7:0]        byte_t;
    typedef logic [15:0]       cpu_addr_t;

    // ================================================
    // Address map
    // ================================================
    localparam mem_addr_t TAP_MEM_START = 23'h020000;
    localparam cpu_addr_t CART_ADDR     = 16'hA000;

    // ROM regions in the machine map
    localparam cpu_addr_t ROM_DRIVE_BASE  = 16'h0000;
    localparam cpu_addr_t ROM_KERNAL_BASE = 16'hE000;
    localparam cpu_addr_t ROM_BASIC_BASE  = 16'hC000;
    localparam cpu_addr_t ROM_CHAR_BASE   = 16'h8000;

    // ================================================
    // Download decoding
    // ================================================
    localparam byte_t IDX_ROM     = 8'h00;
    localparam byte_t IDX_PRG     = 8'h01;
    localparam byte_t IDX_PRG_ALT = 8'h41;
    localparam byte_t IDX_TAP     = 8'h81;

    // Version byte position inside a TAP image
    localparam logic [DL_AW-1:0] TAP_VERSION_OFFSET = 25'd12;

    typedef enum logic [1:0] {
        DL_NONE,
        DL_ROM,
        DL_PRG,
        DL_TAP
    } dl_kind_e;

    // BASIC pointers, low byte at even index, high byte at odd index
    localparam cpu_addr_t INJECT_REGS [8] = '{
        16'h002D, 16'h002E, 16'h002F, 16'h0030,
        16'h0031, 16'h0032, 16'h00AE, 16'h00AF
    };

endpackage

/* logic/mem_req_if.sv */
// ================================================
// Single-beat memory request channel
//   Client holds req and fields until ack
//   Ack lasts one cycle, rdata valid with ack
// ================================================

interface mem_req_if;

    logic                 req;
    logic                 we;
    vic20_pkg::mem_addr_t addr;
    vic20_pkg::byte_t     wdata;
    vic20_pkg::byte_t     rdata;
    logic                 ack;

    // Requesting side
    modport client (
        output req, we, addr, wdata,
        input  rdata, ack
    );

    // Bus master side
    modport server (
        input  req, we, addr, wdata,
        output rdata, ack
    );

endinterface

/* logic/load_sequencer.sv */
// ================================================
// Download sequencer
//   Decodes ROM, PRG and TAP downloads
//   Maps ROM offsets into the ROM regions
//   Parses the PRG load address header
//   Patches BASIC end pointers after a PRG
//   Pulses machine reset for cartridge images
// ================================================

module load_sequencer (
    input  logic                        clk_sys,
    input  logic                        reset,
    input  logic                        dl_active_i,
    input  vic20_pkg::byte_t            dl_index_i,
    input  logic                        dl_wr_i,
    input  logic [vic20_pkg::DL_AW-1:0] dl_addr_i,
    input  vic20_pkg::byte_t            dl_data_i,
    input  logic                        dl_raw_i,
    output logic                        dl_ready_o,
    output logic                        machine_reset_o,
    output logic                        tap_version_o,
    output logic                        tap_restart_o,
    output logic                        prg_load_o,
    output vic20_pkg::cpu_addr_t        prg_load_addr_o,
    output logic                        prg_step_o,
    output logic                        tap_start_o,
    output logic                        tap_step_o,
    input  vic20_pkg::cpu_addr_t        prg_addr_i,
    input  vic20_pkg::mem_addr_t        tap_addr_i,
    mem_req_if.client                   mem
);

    typedef enum logic [1:0] {S_IDLE, S_WRITE, S_INJECT, S_GAP} state_e;

    state_e               state_q;
    vic20_pkg::dl_kind_e  kind_d;
    vic20_pkg::dl_kind_e  kind_q;
    vic20_pkg::cpu_addr_t rom_addr;
    vic20_pkg::cpu_addr_t rom_addr_q;
    vic20_pkg::byte_t     data_q;
    vic20_pkg::byte_t     hdr_lo_q;
    logic [2:0]           inj_idx_q;
    logic                 rom_hit;
    logic                 hdr_byte;
    logic                 wr_accept;
    logic                 wr_needed;
    logic                 prg_seen_q;
    logic                 cart_q;

    // ================================================
    // Download decode
    // ================================================
    always_comb begin
        kind_d = vic20_pkg::DL_NONE;
        if (dl_active_i) begin
            case (dl_index_i)
                vic20_pkg::IDX_ROM:     kind_d = vic20_pkg::DL_ROM;
                vic20_pkg::IDX_PRG,
                vic20_pkg::IDX_PRG_ALT: kind_d = vic20_pkg::DL_PRG;
                vic20_pkg::IDX_TAP:     kind_d = vic20_pkg::DL_TAP;
                default:                kind_d = vic20_pkg::DL_NONE;
            endcase
        end
    end

    // ROM image layout, drive 16K then kernals, BASIC, charset
    always_comb begin
        rom_hit = 1'b1;
        case (dl_addr_i[15:13])
            3'b000, 3'b001: rom_addr = vic20_pkg::ROM_DRIVE_BASE + dl_addr_i[13:0];
            3'b010, 3'b011: rom_addr = vic20_pkg::ROM_KERNAL_BASE + dl_addr_i[12:0];
            3'b100:         rom_addr = vic20_pkg::ROM_BASIC_BASE + dl_addr_i[12:0];
            3'b101:         rom_addr = vic20_pkg::ROM_CHAR_BASE + dl_addr_i[11:0];
            default: begin
                rom_hit  = 1'b0;
                rom_addr = '0;
            end
        endcase
    end

    assign wr_accept = (state_q == S_IDLE) && dl_active_i && dl_wr_i;
    assign hdr_byte  = (kind_d == vic20_pkg::DL_PRG) && !dl_raw_i && (dl_addr_i < 2);
    assign wr_needed = wr_accept &&
                       (((kind_d == vic20_pkg::DL_ROM) && rom_hit) ||
                        ((kind_d == vic20_pkg::DL_PRG) && !hdr_byte) ||
                        (kind_d == vic20_pkg::DL_TAP));

    // ================================================
    // Counter control
    // ================================================
    assign prg_load_o      = wr_accept && (kind_d == vic20_pkg::DL_PRG) &&
                             (dl_addr_i == (dl_raw_i ? 0 : 1));
    assign prg_load_addr_o = dl_raw_i ? vic20_pkg::CART_ADDR : {dl_data_i, hdr_lo_q};
    assign tap_start_o     = wr_accept && (kind_d == vic20_pkg::DL_TAP) && (dl_addr_i == 0);
    assign tap_restart_o   = tap_start_o;
    assign prg_step_o      = (state_q == S_WRITE) && mem.ack && (kind_q == vic20_pkg::DL_PRG);
    assign tap_step_o      = (state_q == S_WRITE) && mem.ack && (kind_q == vic20_pkg::DL_TAP);

    // ================================================
    // Memory request
    // ================================================
    assign mem.req   = (state_q == S_WRITE) || (state_q == S_INJECT);
    assign mem.we    = 1'b1;
    assign mem.addr  = (state_q == S_INJECT) ?
                           vic20_pkg::mem_addr_t'(vic20_pkg::INJECT_REGS[inj_idx_q]) :
                       (kind_q == vic20_pkg::DL_PRG) ? vic20_pkg::mem_addr_t'(prg_addr_i) :
                       (kind_q == vic20_pkg::DL_TAP) ? tap_addr_i :
                       vic20_pkg::mem_addr_t'(rom_addr_q);
    // End pointer is the stepped load pointer
    assign mem.wdata = (state_q != S_INJECT) ? data_q :
                       inj_idx_q[0] ? prg_addr_i[15:8] : prg_addr_i[7:0];

    assign dl_ready_o = (state_q == S_IDLE);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state_q         <= S_IDLE;
            kind_q          <= vic20_pkg::DL_NONE;
            inj_idx_q       <= '0;
            prg_seen_q      <= 1'b0;
            cart_q          <= 1'b0;
            machine_reset_o <= 1'b0;
            tap_version_o   <= 1'b0;
        end else begin
            machine_reset_o <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (wr_needed) begin
                        state_q <= S_WRITE;
                        kind_q  <= kind_d;
                    end else if (prg_seen_q && !dl_active_i) begin
                        state_q    <= S_INJECT;
                        inj_idx_q  <= '0;
                        prg_seen_q <= 1'b0;
                    end
                end
                S_WRITE: begin
                    if (mem.ack) begin
                        state_q <= S_IDLE;
                    end
                end
                S_INJECT: begin
                    if (mem.ack) begin
                        if (inj_idx_q == 3'd7) begin
                            state_q         <= S_IDLE;
                            machine_reset_o <= cart_q;
                        end else begin
                            inj_idx_q <= inj_idx_q + 3'd1;
                            state_q   <= S_GAP;
                        end
                    end
                end
                // Req low for one cycle between injected writes
                S_GAP: state_q <= S_INJECT;
                default: state_q <= S_IDLE;
            endcase
            if (wr_accept && (kind_d == vic20_pkg::DL_PRG)) begin
                prg_seen_q <= 1'b1;
            end
            if (prg_load_o) begin
                cart_q <= (prg_load_addr_o == vic20_pkg::CART_ADDR);
            end
            if (wr_accept && (kind_d == vic20_pkg::DL_TAP) &&
                (dl_addr_i == vic20_pkg::TAP_VERSION_OFFSET)) begin
                tap_version_o <= dl_data_i[0];
            end
        end
    end

    // Byte payload
    always_ff @(posedge clk_sys) begin
        if (wr_accept) begin
            data_q     <= dl_data_i;
            rom_addr_q <= rom_addr;
            if (hdr_byte && (dl_addr_i == 0)) begin
                hdr_lo_q <= dl_data_i;
            end
        end
    end

endmodule

/* logic/load_addr_counter.sv */
// ================================================
// Load pointers
//   PRG pointer, loaded from header or cartridge
//   TAP pointer, started at the tape base
//   Tape end marker for playback
// ================================================

module load_addr_counter (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  logic                 prg_load_i,
    input  vic20_pkg::cpu_addr_t prg_load_addr_i,
    input  logic                 prg_step_i,
    input  logic                 tap_start_i,
    input  logic                 tap_step_i,
    output vic20_pkg::cpu_addr_t prg_addr_o,
    output vic20_pkg::mem_addr_t tap_addr_o,
    output vic20_pkg::mem_addr_t tap_end_o
);

    vic20_pkg::cpu_addr_t prg_addr_q;
    vic20_pkg::mem_addr_t tap_addr_q;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            prg_addr_q <= '0;
            tap_addr_q <= vic20_pkg::TAP_MEM_START;
        end else begin
            // One step per stored data byte
            if (prg_load_i) begin
                prg_addr_q <= prg_load_addr_i;
            end else if (prg_step_i) begin
                prg_addr_q <= prg_addr_q + 16'd1;
            end

            if (tap_start_i) begin
                tap_addr_q <= vic20_pkg::TAP_MEM_START;
            end else if (tap_step_i) begin
                tap_addr_q <= tap_addr_q + 23'd1;
            end
        end
    end

    assign prg_addr_o = prg_addr_q;
    assign tap_addr_o = tap_addr_q;

    // Write pointer sits one past the last stored tape byte
    assign tap_end_o  = tap_addr_q;

endmodule

/* logic/tape_streamer.sv */
// ================================================
// Tape playback streamer
//   Reads stored tape bytes one at a time
//   Holds each byte until the deck accepts it
// ================================================

module tape_streamer (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  logic                 restart_i,
    input  logic                 play_i,
    input  vic20_pkg::mem_addr_t tap_end_i,
    input  logic                 tap_full_i,
    output vic20_pkg::byte_t     tap_data_o,
    output logic                 tap_valid_o,
    mem_req_if.client            mem
);

    typedef enum logic [1:0] {S_IDLE, S_READ, S_HOLD} state_e;

    state_e               state_q;
    vic20_pkg::mem_addr_t play_addr_q;
    vic20_pkg::byte_t     data_q;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state_q     <= S_IDLE;
            play_addr_q <= vic20_pkg::TAP_MEM_START;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (play_i && (play_addr_q < tap_end_i)) begin
                        state_q <= S_READ;
                    end
                end
                S_READ: begin
                    if (mem.ack) begin
                        state_q     <= S_HOLD;
                        play_addr_q <= play_addr_q + 23'd1;
                    end
                end
                // Deck back-pressure
                S_HOLD: begin
                    if (!tap_full_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
            // New tape overrides the playback position
            if (restart_i) begin
                play_addr_q <= vic20_pkg::TAP_MEM_START;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if ((state_q == S_READ) && mem.ack) begin
            data_q <= mem.rdata;
        end
    end

    assign mem.req     = (state_q == S_READ);
    assign mem.we      = 1'b0;
    assign mem.addr    = play_addr_q;
    assign mem.wdata   = '0;

    assign tap_valid_o = (state_q == S_HOLD);
    assign tap_data_o  = data_q;

    // A byte offered to the deck stays until it is taken
    a_valid_held: assert property (
        @(posedge clk_sys) disable iff (reset)
        tap_valid_o && tap_full_i |=> tap_valid_o && $stable(tap_data_o)
    );

endmodule

/* logic/wb_mem_master.sv */
// ================================================
// Wishbone classic master
//   Two clients, loader ahead of tape playback
//   One transfer at a time, never preempted
// ================================================

module wb_mem_master (
    input  logic                 clk_sys,
    input  logic                 reset,
    mem_req_if.server            load,
    mem_req_if.server            tape,
    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output logic                 wb_we_o,
    output vic20_pkg::mem_addr_t wb_adr_o,
    output vic20_pkg::byte_t     wb_dat_o,
    input  vic20_pkg::byte_t     wb_dat_i,
    input  logic                 wb_ack_i
);

    logic gnt_load_q;
    logic gnt_tape_q;

    // ================================================
    // Grant
    // ================================================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            gnt_load_q <= 1'b0;
            gnt_tape_q <= 1'b0;
        end else if (wb_cyc_o) begin
            if (wb_ack_i) begin
                gnt_load_q <= 1'b0;
                gnt_tape_q <= 1'b0;
            end
        end else if (load.req) begin
            gnt_load_q <= 1'b1;
        end else if (tape.req) begin
            gnt_tape_q <= 1'b1;
        end
    end

    // Bus fields latched when the cycle opens
    always_ff @(posedge clk_sys) begin
        if (!wb_cyc_o) begin
            if (load.req) begin
                wb_adr_o <= load.addr;
                wb_we_o  <= load.we;
                wb_dat_o <= load.wdata;
            end else begin
                wb_adr_o <= tape.addr;
                wb_we_o  <= tape.we;
                wb_dat_o <= tape.wdata;
            end
        end
    end

    assign wb_cyc_o   = gnt_load_q | gnt_tape_q;
    assign wb_stb_o   = wb_cyc_o;

    assign load.ack   = gnt_load_q && wb_ack_i;
    assign tape.ack   = gnt_tape_q && wb_ack_i;
    assign load.rdata = wb_dat_i;
    assign tape.rdata = wb_dat_i;

    // ================================================
    // Checks
    // ================================================
    // Cycle closes in the cycle after the slave acks
    a_drop_after_ack: assert property (
        @(posedge clk_sys) disable iff (reset)
        wb_cyc_o && wb_ack_i |=> !wb_cyc_o && !wb_stb_o
    );

    a_adr_stable: assert property (
        @(posedge clk_sys) disable iff (reset)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o)
    );

    // Ack only reaches a client that is still waiting on it
    a_ack_owner: assert property (
        @(posedge clk_sys) disable iff (reset)
        load.ack |-> load.req
    );

    a_ack_owner_tape: assert property (
        @(posedge clk_sys) disable iff (reset)
        tape.ack |-> tape.req
    );

endmodule

/* logic/vic20_loader.sv */
// ================================================
// Loader and tape feed top level
//   Download sequencer and load pointers
//   Tape playback streamer
//   Wishbone master shared by both
// ================================================

module vic20_loader (
    input  logic                        clk_sys,
    input  logic                        reset,
    // Host download bus
    input  logic                        dl_active_i,
    input  vic20_pkg::byte_t            dl_index_i,
    input  logic                        dl_wr_i,
    input  logic [vic20_pkg::DL_AW-1:0] dl_addr_i,
    input  vic20_pkg::byte_t            dl_data_i,
    output logic                        dl_ready_o,
    input  logic                        dl_raw_i,
    // Machine side
    output logic                        machine_reset_o,
    output logic                        tap_version_o,
    // Tape deck
    output vic20_pkg::byte_t            tap_data_o,
    output logic                        tap_valid_o,
    input  logic                        tap_full_i,
    output logic                        tap_restart_o,
    // Wishbone master
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output vic20_pkg::mem_addr_t        wb_adr_o,
    output vic20_pkg::byte_t            wb_dat_o,
    input  vic20_pkg::byte_t            wb_dat_i,
    input  logic                        wb_ack_i
);

    logic                 prg_load;
    vic20_pkg::cpu_addr_t prg_load_addr;
    logic                 prg_step;
    logic                 tap_start;
    logic                 tap_step;
    vic20_pkg::cpu_addr_t prg_addr;
    vic20_pkg::mem_addr_t tap_addr;
    vic20_pkg::mem_addr_t tap_end;

    mem_req_if load_mem ();
    mem_req_if tape_mem ();

    load_sequencer i_load_sequencer (
        .clk_sys, .reset,
        .dl_active_i, .dl_index_i, .dl_wr_i, .dl_addr_i, .dl_data_i, .dl_raw_i,
        .dl_ready_o, .machine_reset_o, .tap_version_o, .tap_restart_o,
        .prg_load_o      (prg_load),
        .prg_load_addr_o (prg_load_addr),
        .prg_step_o      (prg_step),
        .tap_start_o     (tap_start),
        .tap_step_o      (tap_step),
        .prg_addr_i      (prg_addr),
        .tap_addr_i      (tap_addr),
        .mem             (load_mem.client)
    );

    load_addr_counter i_load_addr_counter (
        .clk_sys, .reset,
        .prg_load_i      (prg_load),
        .prg_load_addr_i (prg_load_addr),
        .prg_step_i      (prg_step),
        .tap_start_i     (tap_start),
        .tap_step_i      (tap_step),
        .prg_addr_o      (prg_addr),
        .tap_addr_o      (tap_addr),
        .tap_end_o       (tap_end)
    );

    // Playback runs whenever no download is in progress
    tape_streamer i_tape_streamer (
        .clk_sys, .reset,
        .restart_i  (tap_restart_o),
        .play_i     (!dl_active_i),
        .tap_end_i  (tap_end),
        .tap_full_i,
        .tap_data_o,
        .tap_valid_o,
        .mem        (tape_mem.client)
    );

    wb_mem_master i_wb_mem_master (
        .clk_sys, .reset,
        .load (load_mem.server),
        .tape (tape_mem.server),
        .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_o,
        .wb_dat_i, .wb_ack_i
    );

endmodule

/* test/wb_mem_model.sv */
// ==================================================
// Wishbone classic slave memory for the testbench
//   Byte wide storage over the full memory space
//   Random 0 to 3 wait cycles before each ack
// ==================================================

module wb_mem_model (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  vic20_pkg::mem_addr_t wb_adr_i,
    input  vic20_pkg::byte_t     wb_dat_i,
    output vic20_pkg::byte_t     wb_dat_o,
    output logic                 wb_ack_o
);

    vic20_pkg::byte_t mem [0:(1 << vic20_pkg::MEM_AW) - 1];
    logic [1:0]       wait_q;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= 8'h00;
            wait_q   <= 2'd0;
        end else if (wb_ack_o) begin
            // Master drops the cycle now, pick the next delay
            wb_ack_o <= 1'b0;
            wait_q   <= 2'($urandom_range(0, 3));
        end else if (wb_cyc_i && wb_stb_i) begin
            if (wait_q == 2'd0) begin
                wb_ack_o <= 1'b1;
                if (wb_we_i) begin
                    mem[wb_adr_i] <= wb_dat_i;
                end else begin
                    wb_dat_o <= mem[wb_adr_i];
                end
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

endmodule

/* test/tb_vic20_loader.sv */
// ==================================================
// Testbench for the loader and tape feed
//   Clock, reset and watchdog
//   Download driver and deck/reset monitors
//   Directed tests for reset, PRG, raw PRG, ROM, TAP
// ==================================================

module tb_vic20_loader;

    localparam int PRG_LEN     = 16;
    localparam int RAW_LEN     = 12;
    localparam int ROM_SAMPLES = 10;
    localparam int TAP_LEN     = 40;
    // Every byte moved, the eight pointer writes and tape playback included
    localparam int BYTE_TOTAL  = (PRG_LEN + 2 + 8) + (RAW_LEN + 8) + ROM_SAMPLES + 2 * TAP_LEN;
    localparam int WATCHDOG_CYCLES = BYTE_TOTAL * 20 + 100;

    logic                        clk_sys;
    logic                        reset;
    logic                        dl_active_i;
    vic20_pkg::byte_t            dl_index_i;
    logic                        dl_wr_i;
    logic [vic20_pkg::DL_AW-1:0] dl_addr_i;
    vic20_pkg::byte_t            dl_data_i;
    logic                        dl_ready_o;
    logic                        dl_raw_i;
    logic                        machine_reset_o;
    logic                        tap_version_o;
    vic20_pkg::byte_t            tap_data_o;
    logic                        tap_valid_o;
    logic                        tap_full_i;
    logic                        tap_restart_o;
    logic                        wb_cyc_o;
    logic                        wb_stb_o;
    logic                        wb_we_o;
    vic20_pkg::mem_addr_t        wb_adr_o;
    vic20_pkg::byte_t            wb_dat_o;
    vic20_pkg::byte_t            wb_dat_i;
    logic                        wb_ack_i;

    vic20_pkg::byte_t prg_bytes [PRG_LEN];
    vic20_pkg::byte_t tap_bytes [TAP_LEN];
    vic20_pkg::byte_t tap_rx [$];
    int               reset_pulses;
    int               restart_pulses;
    int               checks;
    int               errors;

    vic20_loader i_vic20_loader (.*);

    wb_mem_model i_wb_mem_model (
        .clk_sys, .reset,
        .wb_cyc_i (wb_cyc_o),
        .wb_stb_i (wb_stb_o),
        .wb_we_i  (wb_we_o),
        .wb_adr_i (wb_adr_o),
        .wb_dat_i (wb_dat_o),
        .wb_dat_o (wb_dat_i),
        .wb_ack_o (wb_ack_i)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("Watchdog timeout, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // Reset and restart pulses, bytes taken by the deck
    always @(posedge clk_sys) begin
        if (!reset && machine_reset_o) begin
            reset_pulses++;
        end
        if (!reset && tap_restart_o) begin
            restart_pulses++;
        end
        if (!reset && tap_valid_o && !tap_full_i) begin
            tap_rx.push_back(tap_data_o);
        end
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic vic20_pkg::byte_t mem_byte(input int unsigned addr);
        return i_wb_mem_model.mem[vic20_pkg::mem_addr_t'(addr)];
    endfunction

    task automatic send_byte(input int offset, input vic20_pkg::byte_t data);
        while (!dl_ready_o) begin
            next_cycle();
        end
        dl_wr_i   = 1'b1;
        dl_addr_i = 25'(offset);
        dl_data_i = data;
        next_cycle();
        dl_wr_i   = 1'b0;
    endtask

    // Last write acked before the host drops dl_active_i
    task automatic finish_download();
        while (!dl_ready_o) begin
            next_cycle();
        end
        dl_active_i = 1'b0;
        next_cycle();
    endtask

    // Drive ROM 16K at 0x0000, kernal at 0x4000, BASIC at 0x8000, charset at 0xA000
    function automatic int unsigned rom_target(input int unsigned offset);
        if (offset < 32'h4000) begin
            return vic20_pkg::ROM_DRIVE_BASE + offset;
        end else if (offset < 32'h6000) begin
            return vic20_pkg::ROM_KERNAL_BASE + (offset - 32'h4000);
        end else if (offset < 32'hA000) begin
            return vic20_pkg::ROM_BASIC_BASE + (offset - 32'h8000);
        end
        return vic20_pkg::ROM_CHAR_BASE + (offset - 32'hA000);
    endfunction

    task automatic run_prg(input logic raw, input vic20_pkg::byte_t index,
                           input vic20_pkg::cpu_addr_t base, input int len);
        int                   first;
        vic20_pkg::cpu_addr_t end_ptr;
        first = raw ? 0 : 2;
        for (int i = 0; i < len; i++) begin
            prg_bytes[i] = 8'($urandom);
        end
        dl_index_i  = index;
        dl_raw_i    = raw;
        dl_active_i = 1'b1;
        next_cycle();
        if (!raw) begin
            send_byte(0, base[7:0]);
            send_byte(1, base[15:8]);
        end
        for (int i = 0; i < len; i++) begin
            send_byte(first + i, prg_bytes[i]);
        end
        finish_download();
        compare("dl_ready_o during pointer writes", dl_ready_o, 0);
        while (!dl_ready_o) begin
            next_cycle();
        end
        dl_raw_i = 1'b0;
        repeat (2) next_cycle();
        for (int i = 0; i < len; i++) begin
            compare($sformatf("PRG byte at %h", base + i), mem_byte(base + i), prg_bytes[i]);
        end
        // Low byte of the end pointer at even positions
        end_ptr = base + 16'(len);
        for (int k = 0; k < 8; k++) begin
            compare($sformatf("pointer register %h", vic20_pkg::INJECT_REGS[k]),
                    mem_byte(vic20_pkg::INJECT_REGS[k]),
                    (k % 2) ? end_ptr[15:8] : end_ptr[7:0]);
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic idle_after_reset();
        compare("dl_ready_o after reset", dl_ready_o, 1);
        compare("wb_cyc_o after reset", wb_cyc_o, 0);
        compare("wb_stb_o after reset", wb_stb_o, 0);
        compare("machine_reset_o after reset", machine_reset_o, 0);
        compare("tap_valid_o after reset", tap_valid_o, 0);
        compare("tap_restart_o after reset", tap_restart_o, 0);
    endtask

    task automatic prg_with_header();
        int pulses;
        pulses = reset_pulses;
        run_prg(1'b0, vic20_pkg::IDX_PRG, 16'h1001, PRG_LEN);
        compare("machine_reset_o pulses after PRG", reset_pulses - pulses, 0);
    endtask

    task automatic prg_raw_cartridge();
        int pulses;
        pulses = reset_pulses;
        run_prg(1'b1, vic20_pkg::IDX_PRG_ALT, vic20_pkg::CART_ADDR, RAW_LEN);
        compare("machine_reset_o pulses after cartridge", reset_pulses - pulses, 1);
    endtask

    task automatic rom_regions();
        int unsigned      offsets [ROM_SAMPLES] = '{
            32'h0000, 32'h1234, 32'h3FFF, 32'h4000, 32'h4ABC,
            32'h5FFF, 32'h8000, 32'h9F0E, 32'hA000, 32'hAFFF
        };
        vic20_pkg::byte_t values [ROM_SAMPLES];
        for (int i = 0; i < ROM_SAMPLES; i++) begin
            values[i] = 8'($urandom);
        end
        dl_index_i  = vic20_pkg::IDX_ROM;
        dl_active_i = 1'b1;
        next_cycle();
        for (int i = 0; i < ROM_SAMPLES; i++) begin
            send_byte(offsets[i], values[i]);
        end
        finish_download();
        for (int i = 0; i < ROM_SAMPLES; i++) begin
            compare($sformatf("ROM offset %h", offsets[i]),
                    mem_byte(rom_target(offsets[i])), values[i]);
        end
    endtask

    task automatic tap_store_and_play();
        int ver_pos;
        int restarts;
        ver_pos  = int'(vic20_pkg::TAP_VERSION_OFFSET);
        restarts = restart_pulses;
        for (int i = 0; i < TAP_LEN; i++) begin
            tap_bytes[i] = 8'($urandom);
        end
        // Version 1 differs from the reset value
        tap_bytes[ver_pos] = tap_bytes[ver_pos] | 8'h01;
        tap_rx.delete();
        dl_index_i  = vic20_pkg::IDX_TAP;
        dl_active_i = 1'b1;
        next_cycle();
        for (int i = 0; i < TAP_LEN; i++) begin
            send_byte(i, tap_bytes[i]);
        end
        finish_download();
        compare("tap_restart_o pulses for a new tape", restart_pulses - restarts, 1);
        compare("tap_version_o", tap_version_o, tap_bytes[ver_pos][0]);
        for (int i = 0; i < TAP_LEN; i++) begin
            compare($sformatf("TAP byte %0d in memory", i),
                    mem_byte(vic20_pkg::TAP_MEM_START + i), tap_bytes[i]);
        end
        // Playback with the deck randomly full
        while (tap_rx.size() < TAP_LEN) begin
            tap_full_i = 1'($urandom_range(0, 1));
            next_cycle();
        end
        tap_full_i = 1'b0;
        repeat (20) next_cycle();
        compare("tap_valid_o after the last byte", tap_valid_o, 0);
        compare("bytes taken by the deck", tap_rx.size(), TAP_LEN);
        for (int i = 0; i < TAP_LEN && i < tap_rx.size(); i++) begin
            compare($sformatf("deck byte %0d", i), tap_rx[i], tap_bytes[i]);
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        void'($urandom(60));
        reset       = 1'b1;
        dl_active_i = 1'b0;
        dl_index_i  = 8'h00;
        dl_wr_i     = 1'b0;
        dl_addr_i   = '0;
        dl_data_i   = 8'h00;
        dl_raw_i    = 1'b0;
        tap_full_i  = 1'b0;
        repeat (4) next_cycle();
        reset = 1'b0;

        idle_after_reset();
        prg_with_header();
        prg_raw_cartridge();
        rom_regions();
        tap_store_and_play();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sources.f */
logic/vic20_pkg.sv
logic/mem_req_if.sv
logic/load_sequencer.sv
logic/load_addr_counter.sv
logic/tape_streamer.sv
logic/wb_mem_master.sv
logic/vic20_loader.sv
test/wb_mem_model.sv
test/tb_vic20_loader.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_vic20_loader
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		echo "Run reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
